// File: tb.f
+incdir+include
hdl/fetch_pkg.sv
hdl/inst_buffer.sv
hdl/predecode.sv
hdl/return_stack.sv
hdl/fetch_frontend.sv
sim/fetch_frontend_chk.sv
sim/fetch_frontend_tb.sv

// File: sim/fetch_frontend_tb.sv
`timescale 1ns/1ps

module fetch_frontend_tb
    import fetch_pkg::*;
;

    typedef struct {
        string       name;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        exc_in;
        inst_fmt_e   fmt;
        logic        comp;
        logic        exc_out;
        logic        push;
        logic        pop;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    fetch_pkt_t   in_pkt;
    logic         out_valid;
    logic         out_ready;
    decoded_pkt_t out_pkt;

    row_t        rows[$];
    int          exp_q[$];
    int          errors = 0;
    int          checked = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr = 32'hcc88_74f0;
    logic [31:0] model_mem [ras_depth];
    int          model_top = 0;
    int          model_cnt = 0;

    fetch_frontend DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    bind predecode fetch_frontend_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] encode(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [4:0] rs1);
        return {7'h00, 5'd2, rs1, 3'b000, rd, opcode};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input logic exc_in,
                           input inst_fmt_e fmt, input logic comp, input logic exc_out,
                           input logic push, input logic pop);
        row_t r;
        r.name    = name;
        r.pc      = 32'h0000_4000 + 32'(rows.size()) * 32'd8;
        r.inst    = inst;
        r.exc_in  = exc_in;
        r.fmt     = fmt;
        r.comp    = comp;
        r.exc_out = exc_out;
        r.push    = push;
        r.pop     = pop;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("load", encode(7'h03, 5'd3, 5'd4), 0, fmt_i, 0, 0, 0, 0);
        add_row("misc-mem", encode(7'h0f, 5'd0, 5'd0), 0, fmt_i, 0, 0, 0, 0);
        add_row("op-imm", encode(7'h13, 5'd1, 5'd1), 0, fmt_i, 0, 0, 0, 0);
        add_row("system", encode(7'h73, 5'd0, 5'd0), 0, fmt_i, 0, 0, 0, 0);
        add_row("jalr plain", encode(7'h67, 5'd0, 5'd6), 0, fmt_i, 0, 0, 0, 0);
        add_row("store", encode(7'h23, 5'd0, 5'd7), 0, fmt_s, 0, 0, 0, 0);
        add_row("amo", encode(7'h2f, 5'd8, 5'd9), 0, fmt_r, 0, 0, 0, 0);
        add_row("op", encode(7'h33, 5'd10, 5'd11), 0, fmt_r, 0, 0, 0, 0);
        add_row("branch", encode(7'h63, 5'd0, 5'd12), 0, fmt_b, 0, 0, 0, 0);
        add_row("auipc", encode(7'h17, 5'd13, 5'd0), 0, fmt_u, 0, 0, 0, 0);
        add_row("lui", encode(7'h37, 5'd14, 5'd0), 0, fmt_u, 0, 0, 0, 0);
        add_row("custom-0", encode(7'h0b, 5'd1, 5'd1), 0, fmt_illegal, 0, 1, 0, 0);
        add_row("opcode 7f", encode(7'h7f, 5'd5, 5'd5), 0, fmt_illegal, 0, 1, 0, 0);
        add_row("c quadrant 1", 32'h0000_4501, 0, fmt_illegal, 1, 0, 0, 0);
        add_row("c.jr with exc", 32'h0000_8082, 1, fmt_illegal, 1, 1, 0, 0);
        add_row("jal with exc", encode(7'h6f, 5'd1, 5'd0), 1, fmt_j, 0, 1, 0, 0);
        add_row("call ra", encode(7'h6f, 5'd1, 5'd0), 0, fmt_j, 0, 0, 1, 0);
        add_row("call t0", encode(7'h6f, 5'd5, 5'd0), 0, fmt_j, 0, 0, 1, 0);
        add_row("jalr call", encode(7'h67, 5'd1, 5'd6), 0, fmt_i, 0, 0, 1, 0);
        add_row("ret ra", encode(7'h67, 5'd0, 5'd1), 0, fmt_i, 0, 0, 0, 1);
        add_row("ret t0", encode(7'h67, 5'd0, 5'd5), 0, fmt_i, 0, 0, 0, 1);
        add_row("pop then push", encode(7'h67, 5'd5, 5'd1), 0, fmt_i, 0, 0, 1, 1);
        add_row("jalr ra ra", encode(7'h67, 5'd1, 5'd1), 0, fmt_i, 0, 0, 1, 0);
        add_row("ret after ra ra", encode(7'h67, 5'd0, 5'd1), 0, fmt_i, 0, 0, 0, 1);
        add_row("ret after swap", encode(7'h67, 5'd0, 5'd5), 0, fmt_i, 0, 0, 0, 1);
        for (int k = 0; k < 10; k++) begin    // Two past the stack depth
            add_row($sformatf("deep call %0d", k), encode(7'h6f, 5'd1, 5'd0),
                    0, fmt_j, 0, 0, 1, 0);
        end
        for (int k = 0; k < 10; k++) begin
            add_row($sformatf("deep ret %0d", k), encode(7'h67, 5'd0, 5'd1),
                    0, fmt_i, 0, 0, 0, 1);
        end
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge clk) begin
        row_t        r;
        logic [31:0] exp_target;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer with no row pending, pc %h", out_pkt.pc);
                errors++;
            end else begin
                r          = rows[exp_q.pop_front()];
                exp_target = (model_cnt == 0) ? 32'h0 : model_mem[model_top];
                check_val({r.name, " pc"}, r.pc, out_pkt.pc);
                check_val({r.name, " inst"}, r.comp ? 32'h0 : r.inst, out_pkt.inst);
                check_val({r.name, " fmt"}, 32'(r.fmt), 32'(out_pkt.fmt));
                check_val({r.name, " compressed"}, 32'(r.comp), 32'(out_pkt.compressed));
                check_val({r.name, " exception"}, 32'(r.exc_out), 32'(out_pkt.exception));
                check_val({r.name, " ras_push"}, 32'(r.push), 32'(out_pkt.ras_push));
                check_val({r.name, " ras_pop"}, 32'(r.pop), 32'(out_pkt.ras_pop));
                check_val({r.name, " ras_target"}, exp_target, out_pkt.ras_target);
                if (r.pop) begin
                    model_top = (model_top + ras_depth - 1) % ras_depth;
                    if (model_cnt > 0) begin
                        model_cnt--;
                    end
                end
                if (r.push) begin    // After the pop
                    model_top            = (model_top + 1) % ras_depth;
                    model_mem[model_top] = r.pc + 32'd4;
                    if (model_cnt < ras_depth) begin
                        model_cnt++;
                    end
                end
                checked++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles with %0d rows checked", cycles, checked);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int          next_row;
        logic        accepted;
        logic [7:0]  rnd;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        out_ready = 1'b0;
        next_row  = 0;
        build_table();
        cycle_limit = 40 * rows.size() + 100;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("reset in_ready", 32'd1, 32'(in_ready));
        check_val("reset out_valid", 32'd0, 32'(out_valid));

        while (checked < rows.size()) begin
            @(negedge clk);
            accepted = in_valid && in_ready;
            @(posedge clk);
            #1;
            take_bits(2, rnd);
            out_ready = (rnd[1:0] != 2'b00);    // Low about one cycle in four
            if (accepted) begin
                exp_q.push_back(next_row);
                next_row++;
                in_valid = 1'b0;
            end
            if (!in_valid && next_row < rows.size()) begin
                take_bits(2, rnd);
                if (rnd[1:0] != 2'b00) begin
                    in_pkt.pc        = rows[next_row].pc;
                    in_pkt.inst      = rows[next_row].inst;
                    in_pkt.exception = rows[next_row].exc_in;
                    in_valid         = 1'b1;
                end
            end
        end

        repeat (5) @(posedge clk);    // Catch stray extra outputs
        if (exp_q.size() != 0) begin
            $display("%0d accepted rows never left the DUT", exp_q.size());
            errors++;
        end
        $display("Rows checked: %0d of %0d, errors: %0d", checked, rows.size(), errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim/fetch_frontend_chk.sv
`timescale 1ns/1ps

module fetch_frontend_chk
    import fetch_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input logic            in_ready,
    input fetch_pkt_t      in_pkt,
    input logic            out_valid,
    input logic            out_ready,
    input decoded_pkt_t    out_pkt,
    input logic [xlen-1:0] top_addr
);

    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_pkt))
        else $error("buffer output dropped or changed while stalled");

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else $error("predecode output dropped or changed while stalled");

    stack_on_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && out_ready) |=> $stable(top_addr))
        else $error("return stack changed without an output transfer");

    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else $error("out_valid high right after reset");

    comp_no_ras: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready && out_pkt.compressed |=> $stable(top_addr))
        else $error("compressed word changed the return stack");

endmodule

// File: hdl/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  fetch_pkt_t   in_pkt,
    output logic         out_valid,
    input  logic         out_ready,
    output decoded_pkt_t out_pkt
);

    logic            buf_valid;
    logic            buf_ready;
    fetch_pkt_t      buf_pkt;
    logic            push_en;
    logic            pop_en;
    logic [xlen-1:0] push_addr;
    logic [xlen-1:0] top_addr;

    inst_buffer u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_pkt   (buf_pkt)
    );

    predecode u_predecode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (buf_valid),
        .in_ready  (buf_ready),
        .in_pkt    (buf_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt),
        .push_en   (push_en),
        .pop_en    (pop_en),
        .push_addr (push_addr),
        .top_addr  (top_addr)
    );

    return_stack u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_en   (push_en),
        .pop_en    (pop_en),
        .push_addr (push_addr),
        .top_addr  (top_addr)
    );

endmodule

// File: hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push_en,
    input  logic            pop_en,
    input  logic [xlen-1:0] push_addr,
    output logic [xlen-1:0] top_addr
);

    logic [xlen-1:0]      mem [ras_depth];
    logic [ras_ptr_w-1:0] top_ptr;
    logic [ras_ptr_w-1:0] ptr_popped;
    logic [ras_ptr_w-1:0] ptr_next;
    logic [ras_cnt_w-1:0] count;
    logic [ras_cnt_w-1:0] cnt_popped;
    logic [ras_cnt_w-1:0] cnt_next;

    // Pop first, then push on the popped pointer
    always_comb begin
        ptr_popped = top_ptr;
        cnt_popped = count;
        if (pop_en) begin
            ptr_popped = (top_ptr == '0) ? ras_ptr_w'(ras_depth - 1) : top_ptr - 1'b1;
            cnt_popped = (count == '0) ? count : count - 1'b1;
        end
        ptr_next = ptr_popped;
        cnt_next = cnt_popped;
        if (push_en) begin
            ptr_next = (ptr_popped == ras_ptr_w'(ras_depth - 1)) ? '0 : ptr_popped + 1'b1;
            if (cnt_popped != ras_cnt_w'(ras_depth)) begin
                cnt_next = cnt_popped + 1'b1;    // Saturates, oldest entry overwritten
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[ptr_next] <= push_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else begin
            top_ptr <= ptr_next;
            count   <= cnt_next;
        end
    end

    assign top_addr = (count == '0) ? '0 : mem[top_ptr];

endmodule

// File: hdl/predecode.sv
`timescale 1ns/1ps

module predecode
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  fetch_pkt_t      in_pkt,
    output logic            out_valid,
    input  logic            out_ready,
    output decoded_pkt_t    out_pkt,
    output logic            push_en,
    output logic            pop_en,
    output logic [xlen-1:0] push_addr,
    input  logic [xlen-1:0] top_addr
);

    logic [4:0]   op_major;
    logic         is_comp;
    logic         is_jal;
    logic         is_jalr;
    logic         rd_link;
    logic         rs1_link;
    logic         exc_merged;
    logic         take;
    logic         xfer;
    inst_fmt_e    fmt_dec;
    decoded_pkt_t nxt;
    decoded_pkt_t out_q;

    assign op_major = in_pkt.inst.base.opcode[6:2];
    assign is_comp  = (in_pkt.inst.comp.lower.quadrant != 2'b11);
    assign is_jal   = (op_major == op_jal);
    assign is_jalr  = (op_major == op_jalr);
    assign rd_link  = (in_pkt.inst.base.rd == link_ra) || (in_pkt.inst.base.rd == link_t0);
    assign rs1_link = (in_pkt.inst.base.rs1 == link_ra) || (in_pkt.inst.base.rs1 == link_t0);

    always_comb begin
        case (op_major)
            op_load, op_misc_mem, op_op_imm, op_jalr, op_system: fmt_dec = fmt_i;
            op_store:                                             fmt_dec = fmt_s;
            op_amo, op_op:                                        fmt_dec = fmt_r;
            op_branch:                                            fmt_dec = fmt_b;
            op_jal:                                               fmt_dec = fmt_j;
            op_auipc, op_lui:                                     fmt_dec = fmt_u;
            default:                                              fmt_dec = fmt_illegal;
        endcase
    end

    assign exc_merged = in_pkt.exception || (fmt_dec == fmt_illegal);

    always_comb begin
        nxt.pc         = in_pkt.pc;
        nxt.ras_target = '0;    // Filled at the output
        if (is_comp) begin
            nxt.inst       = '0;
            nxt.fmt        = fmt_illegal;
            nxt.compressed = 1'b1;
            nxt.exception  = in_pkt.exception;
            nxt.ras_push   = 1'b0;
            nxt.ras_pop    = 1'b0;
        end else begin
            nxt.inst       = in_pkt.inst;
            nxt.fmt        = fmt_dec;
            nxt.compressed = 1'b0;
            nxt.exception  = exc_merged;
            nxt.ras_push   = !exc_merged && (is_jal || is_jalr) && rd_link;
            // Return unless rs1 also names the new link
            nxt.ras_pop    = !exc_merged && is_jalr && rs1_link &&
                             (in_pkt.inst.base.rs1 != in_pkt.inst.base.rd);
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;
    assign xfer     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (take) begin
            out_q <= nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_comb begin
        out_pkt            = out_q;
        out_pkt.ras_target = top_addr;    // Top before this word pops
    end

    assign push_en   = xfer && out_q.ras_push;
    assign pop_en    = xfer && out_q.ras_pop;
    assign push_addr = out_q.pc + xlen'(4);

endmodule

// File: hdl/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  fetch_pkt_t in_pkt,
    output logic       out_valid,
    input  logic       out_ready,
    output fetch_pkt_t out_pkt
);

    fetch_pkt_t           mem [buf_depth];
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    logic [buf_cnt_w-1:0] count;
    logic                 push;
    logic                 pop;

    function automatic logic [buf_ptr_w-1:0] ptr_next(input logic [buf_ptr_w-1:0] p);
        if (p == buf_ptr_w'(buf_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign in_ready  = (count < buf_cnt_w'(buf_depth));
    assign out_valid = (count != '0);
    assign out_pkt   = mem[rd_ptr];    // Head of queue

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;    // Idle or pass-through
                end
            endcase
        end
    end

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

    `include "fetch_defs.svh"

    localparam int xlen      = 32;
    localparam int ras_depth = 8;
    localparam int buf_depth = 4;

    localparam int buf_ptr_w = $clog2(buf_depth);
    localparam int buf_cnt_w = $clog2(buf_depth + 1);
    localparam int ras_ptr_w = $clog2(ras_depth);
    localparam int ras_cnt_w = $clog2(ras_depth + 1);

    typedef enum logic [2:0] {
        fmt_i       = 3'd0,
        fmt_s       = 3'd1,
        fmt_r       = 3'd2,
        fmt_b       = 3'd3,
        fmt_j       = 3'd4,
        fmt_u       = 3'd5,
        fmt_illegal = 3'd7
    } inst_fmt_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } base_view_t;

    typedef struct packed {
        logic [13:0] body;
        logic [1:0]  quadrant;      // 2'b11 means a 32-bit encoding
    } half_view_t;

    typedef struct packed {
        logic [15:0] upper;
        half_view_t  lower;
    } comp_view_t;

    typedef union packed {
        base_view_t base;
        comp_view_t comp;
    } inst_word_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_u      inst;
        logic            exception;
    } fetch_pkt_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_u      inst;
        inst_fmt_e       fmt;
        logic            compressed;
        logic            exception;
        logic            ras_push;
        logic            ras_pop;
        logic [xlen-1:0] ras_target;
    } decoded_pkt_t;

endpackage

// File: include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Major opcode, instruction bits 6 to 2

// I format
localparam logic [4:0] op_load     = 5'b00000;
localparam logic [4:0] op_misc_mem = 5'b00011;
localparam logic [4:0] op_op_imm   = 5'b00100;
localparam logic [4:0] op_jalr     = 5'b11001;
localparam logic [4:0] op_system   = 5'b11100;

// S format
localparam logic [4:0] op_store    = 5'b01000;

// R format
localparam logic [4:0] op_amo      = 5'b01011;
localparam logic [4:0] op_op       = 5'b01100;

// B and J formats
localparam logic [4:0] op_branch   = 5'b11000;
localparam logic [4:0] op_jal      = 5'b11011;

// U format
localparam logic [4:0] op_auipc    = 5'b00101;
localparam logic [4:0] op_lui      = 5'b01101;

localparam logic [4:0] link_ra     = 5'd1;  // x1
localparam logic [4:0] link_t0     = 5'd5;  // x5, alternate link

`endif
